/* source/buf_geom_pkg.sv */
package buf_geom_pkg;

   // one byte lane per bank
   localparam int LANES = 4;
   localparam int LANE_W = 8;

   // wide side sees whole words
   localparam int WORD_W = LANES * LANE_W;

   // 64 words deep in every bank
   localparam int WORD_ADDR_W = 6;
   localparam int WORDS = 2 ** WORD_ADDR_W;

   // narrow side addresses single bytes
   localparam int LANE_SEL_W = $clog2(LANES);
   localparam int BYTE_ADDR_W = WORD_ADDR_W + LANE_SEL_W;

   // same 32 bits, seen as a word or as lane bytes
   typedef union packed {
      logic [WORD_W-1:0] word;
      logic [LANES-1:0][LANE_W-1:0] lanes;
   } word_u;

   // registered command toward the banks
   typedef struct packed {
      logic [LANES-1:0] lane_en;
      logic [WORD_ADDR_W-1:0] addr;
      word_u data;
   } bank_wr_t;

   // byte read request and its response
   typedef struct packed {
      logic en;
      logic [BYTE_ADDR_W-1:0] addr;
   } byte_rd_req_t;

   typedef struct packed {
      logic valid;
      logic [LANE_W-1:0] data;
   } byte_rd_rsp_t;

endpackage

/* source/axil_pkg.sv */
package axil_pkg;

   // bus widths of the write channels
   localparam int AXIL_ADDR_W = 8;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // response codes
   localparam logic [1:0] RESP_OKAY = 2'b00;

   // address write channel, ready travels separately
   typedef struct packed {
      logic valid;
      logic [AXIL_ADDR_W-1:0] addr;
      logic [2:0] prot;
   } axil_aw_t;

   // write data channel
   typedef struct packed {
      logic valid;
      logic [AXIL_DATA_W-1:0] data;
      logic [AXIL_STRB_W-1:0] strb;
   } axil_w_t;

   // write response channel
   typedef struct packed {
      logic valid;
      logic [1:0] resp;
   } axil_b_t;

endpackage

/* source/axil_write_front.sv */
`timescale 1ns/1ps

module axil_write_front (
   input  logic                   clk,
   input  logic                   rst_n,

   // manager side
   input  axil_pkg::axil_aw_t     aw,
   input  axil_pkg::axil_w_t      w,
   input  logic                   bready,
   output logic                   awready,
   output logic                   wready,
   output axil_pkg::axil_b_t      b,

   // toward the banks
   output buf_geom_pkg::bank_wr_t wr
);

   import axil_pkg::*;
   import buf_geom_pkg::*;

   logic accept;
   logic busy;
   logic issued_q;
   logic bvalid_q;

   // a write is in flight from acceptance until bready is seen
   assign busy = issued_q | bvalid_q;

   // address and data must arrive together
   assign accept = aw.valid & w.valid & ~busy;

   assign awready = accept;
   assign wready = accept;

   // lane enables, zero unless a write was just accepted
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr.lane_en <= '0;
      end else if (accept) begin
         wr.lane_en <= w.strb;
      end else begin
         wr.lane_en <= '0;
      end
   end

   // word address and data only move on acceptance
   always_ff @(posedge clk) begin
      if (accept) begin
         // byte offset bits are dropped
         wr.addr <= aw.addr[AXIL_ADDR_W-1:LANE_SEL_W];
         wr.data.word <= w.data;
      end
   end

   // issued_q marks the cycle the banks take the write
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         issued_q <= 1'b0;
      end else begin
         issued_q <= accept;
      end
   end

   // response rises as the banks write, held under back-pressure
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bvalid_q <= 1'b0;
      end else if (issued_q) begin
         bvalid_q <= 1'b1;
      end else if (bready) begin
         bvalid_q <= 1'b0;
      end
   end

   // every byte address maps into the array
   assign b.valid = bvalid_q;
   assign b.resp = RESP_OKAY;

endmodule

/* source/ram_bank.sv */
`timescale 1ns/1ps

module ram_bank (
   input  logic                                 clk,

   // write port
   input  logic                                 we,
   input  logic [buf_geom_pkg::WORD_ADDR_W-1:0] waddr,
   input  logic [buf_geom_pkg::LANE_W-1:0]      wdata,

   // read port
   input  logic                                 re,
   input  logic [buf_geom_pkg::WORD_ADDR_W-1:0] raddr,
   output logic [buf_geom_pkg::LANE_W-1:0]      rdata
);

   import buf_geom_pkg::*;

   logic [LANE_W-1:0] mem [WORDS];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // registered read, same-address write returns old data
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[raddr];
      end
   end

endmodule

/* source/byte_read_port.sv */
`timescale 1ns/1ps

module byte_read_port (
   input  logic                                 clk,
   input  logic                                 rst_n,

   // narrow request and response
   input  buf_geom_pkg::byte_rd_req_t           req,
   output buf_geom_pkg::byte_rd_rsp_t           rsp,

   // shared bank read side
   output logic                                 bank_re,
   output logic [buf_geom_pkg::WORD_ADDR_W-1:0] bank_raddr,
   input  logic [buf_geom_pkg::LANES-1:0][buf_geom_pkg::LANE_W-1:0] bank_rdata
);

   import buf_geom_pkg::*;

   logic [LANE_SEL_W-1:0] lane_sel_q;
   logic rsp_valid_q;

   // every bank gets the same word address
   assign bank_re = req.en;
   assign bank_raddr = req.addr[BYTE_ADDR_W-1:LANE_SEL_W];

   // remember which lane to pick when the bytes come back
   always_ff @(posedge clk) begin
      if (req.en) begin
         lane_sel_q <= req.addr[LANE_SEL_W-1:0];
      end
   end

   // one cycle behind the request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= req.en;
      end
   end

   assign rsp.valid = rsp_valid_q;

   // bank outputs are already registered, so the mux sits after them
   assign rsp.data = bank_rdata[lane_sel_q];

endmodule

/* source/asym_buf_top.sv */
`timescale 1ns/1ps

module asym_buf_top (
   input  logic                        clk,
   input  logic                        rst_n,

   // wide AXI4-Lite write side
   input  axil_pkg::axil_aw_t          aw,
   input  axil_pkg::axil_w_t           w,
   input  logic                        bready,
   output logic                        awready,
   output logic                        wready,
   output axil_pkg::axil_b_t           b,

   // narrow byte read side
   input  buf_geom_pkg::byte_rd_req_t  rd_req,
   output buf_geom_pkg::byte_rd_rsp_t  rd_rsp
);

   import buf_geom_pkg::*;

   bank_wr_t wr;
   logic bank_re;
   logic [WORD_ADDR_W-1:0] bank_raddr;
   logic [LANES-1:0][LANE_W-1:0] bank_rdata;

   axil_write_front front0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .aw      (aw),
      .w       (w),
      .bready  (bready),
      .awready (awready),
      .wready  (wready),
      .b       (b),
      .wr      (wr)
   );

   // one bank per byte lane, each fed its own slice of the word
   for (genvar i = 0; i < LANES; i++) begin : bank_gen
      ram_bank bank0 (
         .clk   (clk),
         .we    (wr.lane_en[i]),
         .waddr (wr.addr),
         .wdata (wr.data.lanes[i]),
         .re    (bank_re),
         .raddr (bank_raddr),
         .rdata (bank_rdata[i])
      );
   end

   byte_read_port rport0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (rd_req),
      .rsp        (rd_rsp),
      .bank_re    (bank_re),
      .bank_raddr (bank_raddr),
      .bank_rdata (bank_rdata)
   );

endmodule

/* sim/asym_buf_tb.sv */
`timescale 1ns/1ps

module asym_buf_tb;

   import axil_pkg::*;
   import buf_geom_pkg::*;

   localparam int TBL_LEN = 22;
   localparam int FILL_WORDS = 64;
   localparam int BYTES = 256;
   localparam int MAX_CYCLES = (TBL_LEN + FILL_WORDS + BYTES) * 8 + 100;
   localparam int WAIT_LIMIT = 20;
   localparam int unsigned SEED = 32'h6205c346;

   localparam logic [1:0] OP_WR = 2'd0;
   localparam logic [1:0] OP_RD = 2'd1;
   localparam logic [1:0] OP_STALL = 2'd2;

   typedef struct packed {
      logic [1:0] op;
      logic [7:0] addr;
      logic [31:0] data;
      logic [3:0] strb;
      logic [7:0] stall;
   } step_t;

   // a stall entry is always followed by the write it blocks
   localparam step_t STEPS [TBL_LEN] = '{
      '{OP_WR, 8'h00, 32'h11223344, 4'hf, 8'd0},
      '{OP_WR, 8'h04, 32'ha5a55a5a, 4'hf, 8'd0},
      '{OP_RD, 8'h00, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h01, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h02, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h03, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h05, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h07, 32'h0, 4'h0, 8'd0},
      '{OP_WR, 8'h00, 32'hdeadbeef, 4'h5, 8'd0},
      '{OP_RD, 8'h00, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h01, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h02, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h03, 32'h0, 4'h0, 8'd0},
      '{OP_STALL, 8'h10, 32'hcafef00d, 4'hf, 8'd6},
      '{OP_WR, 8'h14, 32'h01020304, 4'hf, 8'd0},
      '{OP_RD, 8'h10, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h13, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h14, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h17, 32'h0, 4'h0, 8'd0},
      '{OP_WR, 8'h0b, 32'h87654321, 4'hf, 8'd0},
      '{OP_RD, 8'h08, 32'h0, 4'h0, 8'd0},
      '{OP_RD, 8'h0b, 32'h0, 4'h0, 8'd0}
   };

   logic clk;
   logic rst_n;
   axil_aw_t aw;
   axil_w_t w;
   logic bready;
   logic awready;
   logic wready;
   axil_b_t b;
   byte_rd_req_t rd_req;
   byte_rd_rsp_t rd_rsp;

   // byte-addressed reference model
   logic [7:0] model [BYTES];
   int errors;
   int checks;
   int cycles = 0;

   asym_buf_top dut0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .aw      (aw),
      .w       (w),
      .bready  (bready),
      .awready (awready),
      .wready  (wready),
      .b       (b),
      .rd_req  (rd_req),
      .rd_rsp  (rd_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic check_flag(input string what, input logic got, input logic exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // compare a returned byte with the model
   task automatic check_model(input logic [7:0] addr, input logic [7:0] got);
      checks++;
      assert (got === model[addr]) else begin
         errors++;
         $display("** Error at %0t: byte %h read %h, expected %h",
                  $time, addr, got, model[addr]);
      end
   endtask

   task automatic check_idle(input string phase);
      check_flag({"awready ", phase}, awready, 1'b0);
      check_flag({"wready ", phase}, wready, 1'b0);
      check_flag({"bvalid ", phase}, b.valid, 1'b0);
      check_flag({"rsp valid ", phase}, rd_rsp.valid, 1'b0);
   endtask

   // lane l of a word lands at byte address 4*word + l
   function automatic void update_model(input logic [7:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
      logic [7:0] idx;
      for (int l = 0; l < 4; l++) begin
         idx = {addr[7:2], 2'(l)};
         if (strb[l]) begin
            model[idx] = data[8*l +: 8];
         end
      end
   endfunction

   task automatic write_word(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic hold_resp);
      int waited;
      logic taken;
      waited = 0;
      taken = 1'b0;
      @(negedge clk);
      aw = '{1'b1, addr, 3'b000};
      w = '{1'b1, data, strb};
      bready = ~hold_resp;
      // awready is combinational, so look mid-cycle
      while (!taken && waited < WAIT_LIMIT) begin
         #5;
         taken = awready & wready;
         @(negedge clk);
         waited++;
      end
      aw.valid = 1'b0;
      w.valid = 1'b0;
      assert (taken) else begin
         errors++;
         $display("write to address %h was never accepted", addr);
      end
      waited = 0;
      while (b.valid !== 1'b1 && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      assert (b.valid === 1'b1) else begin
         errors++;
         $display("no write response came for address %h", addr);
      end
      // OKAY is 2'b00
      check_flag("bresp bit 1", b.resp[1], 1'b0);
      check_flag("bresp bit 0", b.resp[0], 1'b0);
   endtask

   // offer the next write while the response is held back
   task automatic hold_check(input step_t nxt, input int hold_cycles);
      aw = '{1'b1, nxt.addr, 3'b000};
      w = '{1'b1, nxt.data, nxt.strb};
      repeat (hold_cycles) begin
         #5;
         check_flag("awready under held response", awready, 1'b0);
         @(negedge clk);
         check_flag("bvalid under held response", b.valid, 1'b1);
      end
      bready = 1'b1;
   endtask

   task automatic read_byte(input logic [7:0] addr);
      @(negedge clk);
      rd_req = '{1'b1, addr};
      @(negedge clk);
      rd_req.en = 1'b0;
      check_flag("rsp valid", rd_rsp.valid, 1'b1);
      check_model(addr, rd_rsp.data);
   endtask

   // one request per cycle, each answered on the next cycle
   task automatic read_sweep();
      for (int a = 0; a <= BYTES; a++) begin
         @(negedge clk);
         if (a > 0) begin
            check_flag("rsp valid in sweep", rd_rsp.valid, 1'b1);
            check_model(8'(a - 1), rd_rsp.data);
         end
         if (a < BYTES) begin
            rd_req = '{1'b1, 8'(a)};
         end else begin
            rd_req.en = 1'b0;
         end
      end
      @(negedge clk);
      check_flag("rsp valid after sweep", rd_rsp.valid, 1'b0);
   endtask

   initial begin
      int unsigned rnd;
      step_t s;
      errors = 0;
      checks = 0;
      void'($urandom(SEED));
      aw = '0;
      w = '0;
      bready = 1'b1;
      rd_req = '0;
      rst_n = 1'b0;

      repeat (10) begin
         @(negedge clk);
         check_idle("in reset");
      end
      rst_n = 1'b1;
      @(negedge clk);
      check_idle("after reset");

      for (int i = 0; i < TBL_LEN; i++) begin
         s = STEPS[i];
         case (s.op)
            OP_WR: begin
               write_word(s.addr, s.data, s.strb, 1'b0);
               update_model(s.addr, s.data, s.strb);
            end
            OP_STALL: begin
               write_word(s.addr, s.data, s.strb, 1'b1);
               update_model(s.addr, s.data, s.strb);
               hold_check(STEPS[i + 1], int'(s.stall));
            end
            default: begin
               read_byte(s.addr);
            end
         endcase
      end

      // random fill of every word, then a full byte sweep
      for (int n = 0; n < FILL_WORDS; n++) begin
         rnd = $urandom();
         write_word(8'(n * 4), rnd, 4'hf, 1'b0);
         update_model(8'(n * 4), rnd, 4'hf);
      end
      read_sweep();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* asym_buf.f */
source/buf_geom_pkg.sv
source/axil_pkg.sv
source/axil_write_front.sv
source/ram_bank.sv
source/byte_read_port.sv
source/asym_buf_top.sv
sim/asym_buf_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing -f asym_buf.f --top-module asym_buf_tb -o asym_buf_sim \
   && ./obj_dir/asym_buf_sim | grep "Done: no errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
